// ==== hw/am_lock_pkg.sv ====
package am_lock_pkg;

	localparam int N_LANES   = 4; // physical lanes
	localparam int N_MARKERS = 4; // one code per logical lane
	localparam int BLOCK_W   = 16;

	// marker codes, top byte 0xA5 on all of them
	localparam logic [BLOCK_W-1:0] AM_CODE [N_MARKERS] = '{
		16'hA5C3,
		16'hA53C,
		16'hA596,
		16'hA569
	};

	localparam int AM_PERIOD = 64; // blocks between markers
	localparam int TIMER_W   = $clog2(AM_PERIOD + 1);

	localparam int LOCK_THR   = 2; // confirms after the first marker
	localparam int UNLOCK_THR = 3; // consecutive misses while locked
	localparam int CONF_W     = $clog2(LOCK_THR + 1);
	localparam int MISS_W     = $clog2(UNLOCK_THR + 1);

	typedef logic [$clog2(N_MARKERS)-1:0] lane_id_t;
	typedef logic [N_MARKERS-1:0]         match_t;

	typedef enum logic [1:0] {
		INIT,
		WAIT_FIRST,
		WAIT_SECOND,
		LOCKED
	} lock_state_t;

endpackage

// ==== hw/am_detector.sv ====
`timescale 1ns/1ns

module am_detector
(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_valid,
	input  logic [am_lock_pkg::BLOCK_W-1:0]    i_block [am_lock_pkg::N_LANES],
	input  am_lock_pkg::match_t                i_match_mask [am_lock_pkg::N_LANES],
	output logic                               o_valid,
	output am_lock_pkg::match_t                o_match_vector [am_lock_pkg::N_LANES],
	output logic [am_lock_pkg::N_LANES-1:0]    o_am_valid
);

	import am_lock_pkg::*;

	// valid delayed to line up with the registered compare
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid;
	end

	// one compare per lane per marker code
	always_ff @(posedge i_clock)
	begin
		for (int l = 0; l < N_LANES; l++)
		begin
			for (int m = 0; m < N_MARKERS; m++)
			begin
				o_match_vector[l][m] <= (i_block[l] == AM_CODE[m]);
			end
		end
	end

	// mask comes straight from each lane's lock machine
	always_comb
	begin
		for (int l = 0; l < N_LANES; l++)
		begin
			o_am_valid[l] = o_valid && |(o_match_vector[l] & i_match_mask[l]);
		end
	end

endmodule

// ==== hw/am_lock_fsm.sv ====
`timescale 1ns/1ns

module am_lock_fsm
(
	input  logic                i_clock,
	input  logic                i_reset,
	input  logic                i_valid,        // delayed valid from detector
	input  logic                i_block_lock,
	input  logic                i_am_valid,     // already masked
	input  am_lock_pkg::match_t i_match_vector,
	output am_lock_pkg::match_t o_match_mask,
	output logic                o_am_lock
);

	import am_lock_pkg::*;

	lock_state_t        state, state_next;
	match_t             match_mask, mask_next;
	logic               am_lock, lock_next;
	logic [CONF_W-1:0]  conf_cnt, conf_next, conf_inc;
	logic [MISS_W-1:0]  miss_cnt, miss_next, miss_inc;
	logic [TIMER_W-1:0] timer;
	logic               timer_done;
	logic               timer_restart;

	assign o_match_mask = match_mask;
	assign o_am_lock    = am_lock;

	assign timer_done = (timer == TIMER_W'(AM_PERIOD)); // lines up with the expected marker
	assign conf_inc   = conf_cnt + 1'b1;
	assign miss_inc   = miss_cnt + 1'b1;

	always_comb
	begin
		state_next    = state;
		mask_next     = match_mask;
		lock_next     = am_lock;
		conf_next     = conf_cnt;
		miss_next     = miss_cnt;
		timer_restart = 1'b0;

		case (state)
			INIT:
			begin
				mask_next  = '1;
				lock_next  = 1'b0;
				state_next = WAIT_FIRST;
			end

			WAIT_FIRST:
			begin
				if (i_am_valid)
				begin
					mask_next     = i_match_vector; // narrow to the code just seen
					timer_restart = 1'b1;
					conf_next     = '0;
					state_next    = WAIT_SECOND;
				end
			end

			WAIT_SECOND:
			begin
				if (timer_done)
				begin
					if (i_am_valid)
					begin
						conf_next = conf_inc;
						if (conf_inc == CONF_W'(LOCK_THR))
						begin
							lock_next  = 1'b1;
							miss_next  = '0;
							state_next = LOCKED;
						end
					end
					else
					begin
						// marker not where expected, start over
						mask_next  = '1;
						state_next = WAIT_FIRST;
					end
				end
			end

			LOCKED:
			begin
				if (timer_done)
				begin
					if (i_am_valid)
						miss_next = '0;
					else if (miss_inc == MISS_W'(UNLOCK_THR))
					begin
						lock_next  = 1'b0;
						mask_next  = '1;
						miss_next  = '0;
						state_next = WAIT_FIRST;
					end
					else
						miss_next = miss_inc;
				end
			end

			default:
			begin
				state_next = INIT;
			end
		endcase
	end

	// block lock loss overrides everything, valid or not
	always_ff @(posedge i_clock)
	begin
		if (i_reset || !i_block_lock)
		begin
			state      <= INIT;
			am_lock    <= 1'b0;
			match_mask <= '1;
			conf_cnt   <= '0;
			miss_cnt   <= '0;
		end
		else if (i_valid)
		begin
			state      <= state_next;
			am_lock    <= lock_next;
			match_mask <= mask_next;
			conf_cnt   <= conf_next;
			miss_cnt   <= miss_next;
		end
	end

	// period timer, counts valid blocks 1..AM_PERIOD
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			timer <= '0;
		else if (i_valid)
			timer <= (timer_restart || timer_done) ? TIMER_W'(1) : timer + 1'b1;
	end

endmodule

// ==== hw/lane_map_monitor.sv ====
`timescale 1ns/1ns

module lane_map_monitor
(
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic [am_lock_pkg::N_LANES-1:0] i_am_lock,
	input  am_lock_pkg::match_t             i_match_mask [am_lock_pkg::N_LANES],
	output am_lock_pkg::lane_id_t           o_lane_id [am_lock_pkg::N_LANES],
	output logic                            o_all_locked,
	output logic                            o_id_conflict
);

	import am_lock_pkg::*;

	lane_id_t id_next [N_LANES];
	logic     conflict_next;

	// one-hot mask to marker index
	function automatic lane_id_t encode(input match_t onehot);
		lane_id_t idx;
		idx = '0;
		for (int m = 0; m < N_MARKERS; m++)
		begin
			if (onehot[m])
				idx = lane_id_t'(m);
		end
		return idx;
	endfunction

	always_comb
	begin
		conflict_next = 1'b0;
		for (int l = 0; l < N_LANES; l++)
		begin
			id_next[l] = i_am_lock[l] ? encode(i_match_mask[l]) : '0; // unlocked reads 0
		end
		// only locked pairs count
		for (int i = 0; i < N_LANES - 1; i++)
		begin
			for (int j = i + 1; j < N_LANES; j++)
			begin
				if (i_am_lock[i] && i_am_lock[j] && (id_next[i] == id_next[j]))
					conflict_next = 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			for (int l = 0; l < N_LANES; l++)
				o_lane_id[l] <= '0;
			o_id_conflict <= 1'b0;
			o_all_locked  <= 1'b0;
		end
		else
		begin
			for (int l = 0; l < N_LANES; l++)
				o_lane_id[l] <= id_next[l];
			o_id_conflict <= conflict_next;
			o_all_locked  <= (&i_am_lock) && !conflict_next;
		end
	end

endmodule

// ==== hw/am_lock_top.sv ====
`timescale 1ns/1ns

module am_lock_top
(
	input  logic                            i_clock,
	input  logic                            i_reset,
	input  logic                            i_valid,
	input  logic [am_lock_pkg::BLOCK_W-1:0] i_block [am_lock_pkg::N_LANES],
	input  logic [am_lock_pkg::N_LANES-1:0] i_block_lock,
	output logic [am_lock_pkg::N_LANES-1:0] o_am_lock,
	output am_lock_pkg::lane_id_t           o_lane_id [am_lock_pkg::N_LANES],
	output logic                            o_all_locked,
	output logic                            o_id_conflict
);

	import am_lock_pkg::*;

	logic               det_valid;               // valid one cycle behind input
	match_t             match_vector [N_LANES];
	logic [N_LANES-1:0] am_valid;
	match_t             match_mask [N_LANES];

	am_detector u_detector (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_valid        (i_valid),
		.i_block        (i_block),
		.i_match_mask   (match_mask),
		.o_valid        (det_valid),
		.o_match_vector (match_vector),
		.o_am_valid     (am_valid)
	);

	for (genvar g = 0; g < N_LANES; g++)
	begin : g_lane
		am_lock_fsm u_fsm (
			.i_clock        (i_clock),
			.i_reset        (i_reset),
			.i_valid        (det_valid),
			.i_block_lock   (i_block_lock[g]),
			.i_am_valid     (am_valid[g]),
			.i_match_vector (match_vector[g]),
			.o_match_mask   (match_mask[g]),
			.o_am_lock      (o_am_lock[g])
		);
	end

	lane_map_monitor u_monitor (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_am_lock     (o_am_lock),
		.i_match_mask  (match_mask),
		.o_lane_id     (o_lane_id),
		.o_all_locked  (o_all_locked),
		.o_id_conflict (o_id_conflict)
	);

endmodule

// ==== bench/am_lock_properties.sv ====
`timescale 1ns/1ns

module am_lock_properties
(
	input logic                i_clock,
	input logic                i_reset,
	input logic                i_valid,
	input logic                i_block_lock,
	input logic                i_timer_done,
	input logic                i_am_lock,
	input am_lock_pkg::match_t i_match_mask
);

	// lock only rises on the block where the period timer expired
	lock_rise_on_expiry: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(i_am_lock) |-> $past(i_timer_done && i_valid))
		else $error("am_lock rose without a period timer expiry");

	mask_onehot_when_locked: assert property (@(posedge i_clock) disable iff (i_reset)
		i_am_lock |-> $onehot(i_match_mask))
		else $error("match mask not one-hot while locked");

	unlock_after_block_lock_loss: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_block_lock |=> !i_am_lock)
		else $error("am_lock still high one cycle after block lock fell");

endmodule

// ==== bench/am_lock_checker.sv ====
`timescale 1ns/1ns

module am_lock_checker
(
	input  logic                            i_clock,
	input  logic                            i_check, // phase end strobe
	input  logic                            i_done,
	input  logic [am_lock_pkg::N_LANES-1:0] i_exp_am_lock,
	input  am_lock_pkg::lane_id_t           i_exp_lane_id [am_lock_pkg::N_LANES],
	input  logic                            i_exp_all_locked,
	input  logic                            i_exp_id_conflict,
	input  logic [am_lock_pkg::N_LANES-1:0] i_am_lock,
	input  am_lock_pkg::lane_id_t           i_lane_id [am_lock_pkg::N_LANES],
	input  logic                            i_all_locked,
	input  logic                            i_id_conflict,
	output int                              o_mismatch_count,
	output int                              o_other_count,
	output int                              o_check_count
);

	import am_lock_pkg::*;

	int mismatches = 0;
	int others     = 0;
	int checks     = 0;

	assign o_mismatch_count = mismatches;
	assign o_other_count    = others;
	assign o_check_count    = checks;

	task automatic compare_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			$display("mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
			mismatches++;
		end
	endtask

	always @(posedge i_clock)
	begin
		if (i_check)
		begin
			checks++;
			compare_value("o_am_lock", 8'(i_exp_am_lock), 8'(i_am_lock));
			for (int l = 0; l < N_LANES; l++)
				compare_value($sformatf("o_lane_id[%0d]", l), 8'(i_exp_lane_id[l]),
					8'(i_lane_id[l]));
			compare_value("o_all_locked", 8'(i_exp_all_locked), 8'(i_all_locked));
			compare_value("o_id_conflict", 8'(i_exp_id_conflict), 8'(i_id_conflict));
		end
		if (i_done && checks == 0)
		begin
			$display("error: the run ended without a single phase check");
			others++;
		end
	end

endmodule

// ==== bench/tb_am_lock.sv ====
`timescale 1ns/1ns

module tb_am_lock;

	import am_lock_pkg::*;

	localparam int CLOCK_HALF   = 20; // 40 ns period
	localparam int RESET_CYCLES = 16;
	localparam int SEED         = 17;
	localparam int FIELDS       = 17; // hex words per stim row
	localparam int MAX_PHASES   = 16;
	localparam int MARGIN       = 400;

	logic               clock = 1'b0;
	logic               reset;
	logic               valid;
	logic [BLOCK_W-1:0] block [N_LANES];
	logic [N_LANES-1:0] block_lock;
	logic [N_LANES-1:0] am_lock;
	lane_id_t           lane_id [N_LANES];
	logic               all_locked;
	logic               id_conflict;

	logic               check;
	logic               done;
	logic [N_LANES-1:0] exp_am_lock;
	lane_id_t           exp_lane_id [N_LANES];
	logic               exp_all_locked;
	logic               exp_id_conflict;
	int                 mismatch_count;
	int                 other_count;
	int                 check_count;

	logic [7:0] stim_mem [MAX_PHASES * FIELDS];
	int         marker_idx [N_LANES]; // current phase, per lane
	int         lane_mode [N_LANES];  // 0 good, 1 missing, 2 alternate code
	int         limit_cycles = 0;

	always #CLOCK_HALF clock = ~clock;

	am_lock_top dut (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_valid       (valid),
		.i_block       (block),
		.i_block_lock  (block_lock),
		.o_am_lock     (am_lock),
		.o_lane_id     (lane_id),
		.o_all_locked  (all_locked),
		.o_id_conflict (id_conflict)
	);

	am_lock_checker u_checker (
		.i_clock           (clock),
		.i_check           (check),
		.i_done            (done),
		.i_exp_am_lock     (exp_am_lock),
		.i_exp_lane_id     (exp_lane_id),
		.i_exp_all_locked  (exp_all_locked),
		.i_exp_id_conflict (exp_id_conflict),
		.i_am_lock         (am_lock),
		.i_lane_id         (lane_id),
		.i_all_locked      (all_locked),
		.i_id_conflict     (id_conflict),
		.o_mismatch_count  (mismatch_count),
		.o_other_count     (other_count),
		.o_check_count     (check_count)
	);

	bind am_lock_fsm am_lock_properties u_properties (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_valid      (i_valid),
		.i_block_lock (i_block_lock),
		.i_timer_done (timer_done),
		.i_am_lock    (am_lock),
		.i_match_mask (match_mask)
	);

	// random filler, never in the 0xA5 marker space
	function automatic logic [BLOCK_W-1:0] filler_block();
		logic [31:0] r;
		r = $urandom;
		if (r[15:8] == 8'hA5)
			r[15:8] = 8'h5A;
		return r[BLOCK_W-1:0];
	endfunction

	function automatic logic [BLOCK_W-1:0] lane_block(input int l, input int period);
		int code;
		code = marker_idx[l];
		if (lane_mode[l] == 1)
			return filler_block(); // marker left out
		if (lane_mode[l] == 2 && period % 2 == 1)
			code = (code + 1) % N_MARKERS;
		return AM_CODE[code];
	endfunction

	// one valid block, after a random number of idle cycles
	task automatic drive_block(input bit marker_slot, input int period);
		@(posedge clock);
		while (($urandom % 8) == 0)
		begin
			valid <= 1'b0;
			@(posedge clock);
		end
		valid <= 1'b1;
		for (int l = 0; l < N_LANES; l++)
			block[l] <= marker_slot ? lane_block(l, period) : filler_block();
	endtask

	task automatic run_phase(input int phase);
		int base;
		int periods;
		base    = phase * FIELDS;
		periods = int'(stim_mem[base]);
		for (int l = 0; l < N_LANES; l++)
		begin
			marker_idx[l] = int'(stim_mem[base + 1 + l][1:0]);
			lane_mode[l]  = int'(stim_mem[base + 5 + l]);
		end
		@(posedge clock);
		block_lock <= stim_mem[base + 9][N_LANES-1:0];
		for (int p = 0; p < periods; p++)
			for (int b = 0; b < AM_PERIOD; b++)
				drive_block(b == 0, p);
		@(posedge clock);
		valid           <= 1'b0;
		exp_am_lock     <= stim_mem[base + 10][N_LANES-1:0];
		for (int l = 0; l < N_LANES; l++)
			exp_lane_id[l] <= stim_mem[base + 11 + l][1:0];
		exp_all_locked  <= stim_mem[base + 15][0];
		exp_id_conflict <= stim_mem[base + 16][0];
		check           <= 1'b1;
		@(posedge clock);
		check <= 1'b0;
	endtask

	task automatic finish_run(input bit timed_out);
		int others;
		others = other_count + (timed_out ? 1 : 0);
		$display("closing: %0d mismatches, %0d other errors, %0d checks run",
			mismatch_count, others, check_count);
		if (mismatch_count == 0 && others == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	initial
	begin
		int total_periods;
		int n_phases;
		void'($urandom(SEED));
		reset           <= 1'b1;
		valid           <= 1'b0;
		block_lock      <= '1;
		check           <= 1'b0;
		done            <= 1'b0;
		exp_am_lock     <= '0;
		exp_all_locked  <= 1'b0;
		exp_id_conflict <= 1'b0;
		for (int l = 0; l < N_LANES; l++)
		begin
			block[l]       <= '0;
			exp_lane_id[l] <= '0;
		end
		$readmemh("bench/am_lock_stim.txt", stim_mem);
		total_periods = 0;
		n_phases      = 0;
		while (n_phases < MAX_PHASES && stim_mem[n_phases * FIELDS] != 8'd0)
		begin
			total_periods += int'(stim_mem[n_phases * FIELDS]);
			n_phases++;
		end
		limit_cycles = total_periods * AM_PERIOD * 2 + RESET_CYCLES + MARGIN;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < n_phases; i++)
			run_phase(i);
		@(posedge clock);
		done <= 1'b1;
		@(posedge clock);
		done <= 1'b0;
		@(posedge clock); // checker counts settle
		finish_run(1'b0);
	end

	initial
	begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: phases still running after %0d cycles", limit_cycles);
		finish_run(1'b1);
	end

endmodule

// ==== bench/am_lock_stim.txt ====
// periods | marker idx lane0..3 | mode lane0..3 (0 good 1 missing 2 alternate) | block lock mask
// expected: am_lock mask | lane id lane0..3 | all_locked | id_conflict ; all zero row ends
05 2 3 0 1 0 0 0 0 f f 2 3 0 1 1 0
02 2 3 0 1 0 1 0 0 f f 2 3 0 1 1 0
02 2 3 0 1 0 0 0 0 f f 2 3 0 1 1 0
03 2 3 0 1 0 1 0 0 f d 2 0 0 1 0 0
06 2 3 0 1 0 2 0 0 f d 2 0 0 1 0 0
04 2 3 0 1 0 0 0 0 f f 2 3 0 1 1 0
07 2 3 0 2 0 0 0 0 f f 2 3 0 2 0 1
02 2 3 0 2 0 0 0 0 b b 2 3 0 2 0 1
04 2 3 0 2 0 0 0 0 f f 2 3 0 2 0 1
07 2 3 0 1 0 0 0 0 f f 2 3 0 1 1 0
00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== compile.f ====
hw/am_lock_pkg.sv
hw/am_detector.sv
hw/am_lock_fsm.sv
hw/lane_map_monitor.sv
hw/am_lock_top.sv
bench/am_lock_properties.sv
bench/am_lock_checker.sv
bench/tb_am_lock.sv

// ==== Makefile ====
RTL = hw/am_lock_pkg.sv hw/am_detector.sv hw/am_lock_fsm.sv hw/lane_map_monitor.sv \
	hw/am_lock_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module am_lock_top $(RTL)

sim:
	verilator --binary --timing --assert --top-module tb_am_lock -f compile.f
	./obj_dir/Vtb_am_lock > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test failures found" sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
